/* lsb_pkg.sv */
`default_nettype none

package lsb_pkg;

    // ****************************************
    // Sizes
    // ****************************************

    localparam int unsigned XLEN          = 32;
    localparam int unsigned TAG_W         = 3;
    localparam int unsigned LSB_DEPTH     = 8;   // One entry per ROB tag.
    localparam int unsigned FQ_DEPTH      = 8;
    localparam int unsigned FQ_PTR_W      = 3;
    localparam int unsigned FQ_FULL_LEVEL = 6;   // Two slots of slack for requests in flight.
    localparam int unsigned RAM_AW        = 10;  // Addresses wrap modulo 1024.

    // ****************************************
    // Types
    // ****************************************

    typedef logic [TAG_W-1:0] tag_t;

    localparam tag_t TAG_NONE = '0;  // Tag 0 means no operation.

    // Codes follow the core's load/store opcode subset.
    typedef enum logic [4:0] {
        LB  = 5'b10010,
        LH  = 5'b10011,
        LW  = 5'b10100,
        LBU = 5'b10101,
        LHU = 5'b10110,
        SB  = 5'b10111,
        SH  = 5'b11000,
        SW  = 5'b11001
    } mem_op_t;

    typedef struct packed {
        tag_t            tag;
        mem_op_t         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;   // Store data.
    } mem_req_t;

    typedef struct packed {
        tag_t            tag;
        logic [XLEN-1:0] value;  // Zero for a store.
    } mem_res_t;

endpackage

`default_nettype wire

/* lsb_entry_buf.sv */
`timescale 1ns/1ns
`default_nettype none

module lsb_entry_buf (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     issue_valid,
    input  wire lsb_pkg::mem_req_t  issue,
    input  wire lsb_pkg::tag_t      commit_tag,
    input  wire                     entry_done,
    input  wire lsb_pkg::tag_t      done_tag,
    output logic                    sel_valid,
    output lsb_pkg::mem_req_t       sel_req
);

    import lsb_pkg::*;

    mem_req_t               entry_q [LSB_DEPTH];
    logic [LSB_DEPTH-1:0]   busy_q;

    // ****************************************
    // Entry storage
    // ****************************************

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            entry_q[issue.tag] <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy_q <= '0;
        end else begin
            if (entry_done) begin
                busy_q[done_tag] <= 1'b0;
            end
            if (issue_valid) begin
                busy_q[issue.tag] <= 1'b1;  // A new issue wins over a completion.
            end
        end
    end

    // ****************************************
    // Commit selection
    // ****************************************

    assign sel_valid = (commit_tag != TAG_NONE) && busy_q[commit_tag];
    assign sel_req   = entry_q[commit_tag];

    // ****************************************
    // Checks
    // ****************************************

    a_issue_tag_nonzero: assert property (
        @(posedge clk) disable iff (!rst)
        issue_valid |-> (issue.tag != TAG_NONE)
    ) else $error("issue with tag 0");

    // The sequencer only finishes work that this buffer handed out.
    a_done_on_busy: assert property (
        @(posedge clk) disable iff (!rst)
        entry_done |-> busy_q[done_tag]
    ) else $error("entry_done for idle tag %0d", done_tag);

endmodule

`default_nettype wire

/* fetch_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_queue (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          push,
    input  wire [lsb_pkg::XLEN-1:0]      push_pc,
    input  wire                          pop,
    output logic                         head_valid,
    output logic [lsb_pkg::XLEN-1:0]     head_pc,
    output logic                         full
);

    import lsb_pkg::*;

    logic [XLEN-1:0]     pc_q [FQ_DEPTH];
    logic [FQ_PTR_W-1:0] head_q;
    logic [FQ_PTR_W-1:0] tail_q;
    logic [FQ_PTR_W:0]   count_q;
    logic [FQ_PTR_W:0]   count_d;

    always_comb begin
        count_d = count_q;
        case ({push, pop})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;  // Push and pop together keep the level.
        endcase
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_q[tail_q] <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            full    <= 1'b0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;  // Wraps at FQ_DEPTH.
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_d;
            full    <= (count_d >= FQ_FULL_LEVEL);
        end
    end

    assign head_valid = (count_q != '0);
    assign head_pc    = pc_q[head_q];

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst)
        push |-> (count_q != FQ_DEPTH)
    ) else $error("fetch push into full queue");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst)
        pop |-> (count_q != '0)
    ) else $error("fetch pop from empty queue");

endmodule

`default_nettype wire

/* mem_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_sequencer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          sel_valid,
    input  wire lsb_pkg::mem_req_t       sel_req,
    input  wire                          head_valid,
    input  wire [lsb_pkg::XLEN-1:0]      head_pc,
    output logic                         entry_done,
    output lsb_pkg::tag_t                done_tag,
    output logic                         fetch_pop,
    output logic [lsb_pkg::RAM_AW-1:0]   ram_addr,
    output logic                         ram_we,
    output logic [7:0]                   ram_wdata,
    input  wire [7:0]                    ram_rdata,
    output logic                         mem_ready,
    output lsb_pkg::mem_res_t            mem_result,
    output logic                         ins_ready,
    output logic [lsb_pkg::XLEN-1:0]     ins_value
);

    import lsb_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_COLLECT,
        ST_DONE
    } seq_state_t;

    seq_state_t         state;
    logic               is_fetch;
    logic [1:0]         cnt;        // Byte position.
    logic [1:0]         len_m1;     // Access length minus one.
    tag_t               cur_tag;
    mem_op_t            cur_op;
    logic [RAM_AW-1:0]  cur_addr;
    logic [XLEN-1:0]    word_q;     // Store data, or bytes collected so far.
    logic [XLEN-1:0]    rd_word;
    logic [XLEN-1:0]    load_value;

    function automatic logic op_is_store(input mem_op_t op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    function automatic logic [1:0] op_len_m1(input mem_op_t op);
        case (op)
            LW, SW:      return 2'd3;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] extend_load(input mem_op_t op, input logic [XLEN-1:0] w);
        case (op)
            LB:      return {{24{w[7]}}, w[7:0]};
            LBU:     return {24'd0, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LHU:     return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    // ****************************************
    // Datapath
    // ****************************************

    // Last byte arrives from the RAM in the collect cycle.
    always_comb begin
        rd_word = word_q;
        rd_word[8*len_m1 +: 8] = ram_rdata;
    end

    assign load_value = extend_load(cur_op, rd_word);

    assign ram_addr  = cur_addr + RAM_AW'(cnt);
    assign ram_we    = (state == ST_WRITE);
    assign ram_wdata = word_q[8*cnt +: 8];  // Low byte first.

    assign entry_done = (state == ST_DONE) && !is_fetch;
    assign fetch_pop  = (state == ST_DONE) && is_fetch;
    assign done_tag   = cur_tag;

    // ****************************************
    // Control
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= ST_IDLE;
            is_fetch   <= 1'b0;
            cnt        <= '0;
            len_m1     <= '0;
            mem_ready  <= 1'b0;
            ins_ready  <= 1'b0;
            mem_result <= '0;
            ins_value  <= '0;
        end else begin
            mem_ready <= 1'b0;
            ins_ready <= 1'b0;
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (sel_valid) begin  // Committed work goes before fetches.
                        is_fetch <= 1'b0;
                        cur_tag  <= sel_req.tag;
                        cur_op   <= sel_req.op;
                        cur_addr <= sel_req.addr[RAM_AW-1:0];
                        word_q   <= sel_req.data;
                        len_m1   <= op_len_m1(sel_req.op);
                        state    <= op_is_store(sel_req.op) ? ST_WRITE : ST_READ;
                    end else if (head_valid) begin
                        is_fetch <= 1'b1;
                        cur_addr <= head_pc[RAM_AW-1:0];
                        len_m1   <= 2'd3;
                        state    <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == len_m1) begin
                        state            <= ST_DONE;
                        mem_ready        <= 1'b1;
                        mem_result.tag   <= cur_tag;
                        mem_result.value <= '0;
                    end
                end
                ST_READ: begin
                    if (cnt != 2'd0) begin
                        word_q[8*(cnt - 2'd1) +: 8] <= ram_rdata;  // Byte of last cycle.
                    end
                    if (cnt == len_m1) begin
                        state <= ST_COLLECT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_COLLECT: begin
                    state <= ST_DONE;
                    if (is_fetch) begin
                        ins_ready <= 1'b1;
                        ins_value <= rd_word;
                    end else begin
                        mem_ready        <= 1'b1;
                        mem_result.tag   <= cur_tag;
                        mem_result.value <= load_value;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ****************************************
    // Checks
    // ****************************************

    a_one_ready: assert property (
        @(posedge clk) disable iff (!rst)
        !(mem_ready && ins_ready)
    ) else $error("mem_ready and ins_ready together");

    a_we_on_store: assert property (
        @(posedge clk) disable iff (!rst)
        ram_we |-> (!is_fetch && op_is_store(cur_op))
    ) else $error("ram_we outside a store");

endmodule

`default_nettype wire

/* byte_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_ram (
    input  wire                          clk,
    input  wire                          we,
    input  wire [lsb_pkg::RAM_AW-1:0]    addr,
    input  wire [7:0]                    wdata,
    output logic [7:0]                   rdata
);

    import lsb_pkg::*;

    logic [7:0] mem [2**RAM_AW];

    // Read data follows the address by one cycle.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // Old byte on a write cycle.
    end

endmodule

`default_nettype wire

/* lsb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsb_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          issue_valid,
    input  wire lsb_pkg::mem_req_t       issue,
    input  wire lsb_pkg::tag_t           commit_tag,
    input  wire                          fetch_req,
    input  wire [lsb_pkg::XLEN-1:0]      fetch_pc,
    output logic                         fetch_full,
    output logic                         ins_ready,
    output logic [lsb_pkg::XLEN-1:0]     ins_value,
    output logic                         mem_ready,
    output lsb_pkg::mem_res_t            mem_result
);

    import lsb_pkg::*;

    logic              sel_valid;
    mem_req_t          sel_req;
    logic              entry_done;
    tag_t              done_tag;
    logic              head_valid;
    logic [XLEN-1:0]   head_pc;
    logic              fetch_pop;
    logic [RAM_AW-1:0] ram_addr;
    logic              ram_we;
    logic [7:0]        ram_wdata;
    logic [7:0]        ram_rdata;

    lsb_entry_buf u_entry_buf (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .commit_tag  (commit_tag),
        .entry_done  (entry_done),
        .done_tag    (done_tag),
        .sel_valid   (sel_valid),
        .sel_req     (sel_req)
    );

    fetch_queue u_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (fetch_req),
        .push_pc    (fetch_pc),
        .pop        (fetch_pop),
        .head_valid (head_valid),
        .head_pc    (head_pc),
        .full       (fetch_full)
    );

    mem_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .sel_valid  (sel_valid),
        .sel_req    (sel_req),
        .head_valid (head_valid),
        .head_pc    (head_pc),
        .entry_done (entry_done),
        .done_tag   (done_tag),
        .fetch_pop  (fetch_pop),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .mem_ready  (mem_ready),
        .mem_result (mem_result),
        .ins_ready  (ins_ready),
        .ins_value  (ins_value)
    );

    byte_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* tb_lsb.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lsb;

    import lsb_pkg::*;

    localparam int N_OPS          = 40;
    localparam int CYCLES_PER_OP  = 12;
    localparam int TIMEOUT_CYCLES = N_OPS * CYCLES_PER_OP + 120;  // Reset and idle gaps.

    logic            clk;
    logic            rst;
    logic            issue_valid;
    mem_req_t        issue;
    tag_t            commit_tag;
    logic            fetch_req;
    logic [XLEN-1:0] fetch_pc;
    logic            fetch_full;
    logic            ins_ready;
    logic [XLEN-1:0] ins_value;
    logic            mem_ready;
    mem_res_t        mem_result;

    logic [7:0]      model_mem [2**RAM_AW];
    mem_res_t        exp_mem_q [$];
    logic [XLEN-1:0] exp_fetch_q [$];
    logic [31:0]     waddr [4];
    mem_op_t         narrow_ops [4] = '{LB, LBU, LH, LHU};
    logic [31:0]     rng = 32'd9907;
    tag_t            cur_tag = 3'd0;
    int              pending = 0;      // Fetches pushed but not yet returned.
    int              cycles = 0;
    logic            started = 1'b0;
    logic            mem_first = 1'b0;

    lsb_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .commit_tag  (commit_tag),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_full  (fetch_full),
        .ins_ready   (ins_ready),
        .ins_value   (ins_value),
        .mem_ready   (mem_ready),
        .mem_result  (mem_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ****************************************
    // Failure reporting
    // ****************************************

    task automatic fail_now();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
        fail_now();
    endtask

    task automatic report_fault(input string what);
        $display("%s", what);
        fail_now();
    endtask

    // ****************************************
    // Reference model
    // ****************************************

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [RAM_AW-1:0] a;
        a = addr[RAM_AW-1:0];
        return {model_mem[a + 10'd3], model_mem[a + 10'd2], model_mem[a + 10'd1], model_mem[a]};
    endfunction

    function automatic logic [31:0] model_load(input mem_op_t op, input logic [31:0] addr);
        logic [31:0] w;
        w = model_word(addr);
        case (op)
            LB:      return 32'($signed(w[7:0]));
            LBU:     return 32'(w[7:0]);
            LH:      return 32'($signed(w[15:0]));
            LHU:     return 32'(w[15:0]);
            default: return w;
        endcase
    endfunction

    function automatic void write_model(input logic [31:0] addr, input logic [31:0] data,
                                        input int nbytes);
        for (int i = 0; i < nbytes; i++) begin
            model_mem[addr[RAM_AW-1:0] + RAM_AW'(i)] = data[8*i +: 8];  // Low byte first.
        end
    endfunction

    function automatic void expect_result(input tag_t tag, input mem_op_t op,
                                          input logic [31:0] addr, input logic [31:0] data);
        mem_res_t res;
        res.tag   = tag;
        res.value = '0;
        case (op)
            SB:      write_model(addr, data, 1);
            SH:      write_model(addr, data, 2);
            SW:      write_model(addr, data, 4);
            default: res.value = model_load(op, addr);
        endcase
        exp_mem_q.push_back(res);
    endfunction

    // ****************************************
    // Stimulus tasks
    // ****************************************

    task automatic issue_op(input tag_t tag, input mem_op_t op, input logic [31:0] addr,
                            input logic [31:0] data);
        mem_req_t req;
        req.tag  = tag;
        req.op   = op;
        req.addr = addr;
        req.data = data;
        @(posedge clk);
        issue_valid <= 1'b1;
        issue       <= req;
        started     <= 1'b1;
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic wait_result(input tag_t tag);
        do begin
            @(posedge clk);
        end while (!(mem_ready && mem_result.tag == tag));
        commit_tag <= TAG_NONE;
    endtask

    task automatic mem_access(input mem_op_t op, input logic [31:0] addr,
                              input logic [31:0] data);
        cur_tag = (cur_tag == 3'd7) ? 3'd1 : cur_tag + 3'd1;
        issue_op(cur_tag, op, addr, data);
        expect_result(cur_tag, op, addr, data);
        @(posedge clk);
        commit_tag <= cur_tag;
        wait_result(cur_tag);
    endtask

    task automatic push_fetch(input logic [31:0] pc);
        fetch_req <= 1'b1;
        fetch_pc  <= pc;
        started   <= 1'b1;
        exp_fetch_q.push_back(model_word(pc));
    endtask

    // ****************************************
    // Checks
    // ****************************************

    always @(posedge clk) begin
        if (rst) begin
            if ((mem_ready || ins_ready) && mem_first) begin
                assert (mem_ready) else report_fault("A fetch finished before the committed load.");
                mem_first <= 1'b0;
            end
            if (mem_ready) begin
                if (exp_mem_q.size() == 0) begin
                    report_fault("mem_ready pulsed with no operation committed.");
                end else begin
                    assert (mem_result.tag == exp_mem_q[0].tag)
                        else report_value("mem_result.tag", mem_result.tag, exp_mem_q[0].tag);
                    assert (mem_result.value == exp_mem_q[0].value)
                        else report_value("mem_result.value", mem_result.value, exp_mem_q[0].value);
                    void'(exp_mem_q.pop_front());
                end
            end
            if (ins_ready) begin
                if (exp_fetch_q.size() == 0) begin
                    report_fault("ins_ready pulsed with no fetch pending.");
                end else begin
                    assert (ins_value == exp_fetch_q[0])
                        else report_value("ins_value", ins_value, exp_fetch_q[0]);
                    void'(exp_fetch_q.pop_front());
                end
            end
            pending <= pending + int'(fetch_req) - int'(ins_ready);
        end
    end

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (!rst)
        !started |-> (!mem_ready && !ins_ready && !fetch_full)
    ) else report_fault("A ready or full output rose before any operation.");

    a_full_level: assert property (
        @(posedge clk) disable iff (!rst)
        fetch_full == (pending >= FQ_FULL_LEVEL)
    ) else report_value("fetch_full", 32'(fetch_full), 32'(pending >= FQ_FULL_LEVEL));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_fault("Timeout, the run did not finish within the cycle limit.");
        end
    end

    // ****************************************
    // Test sequence
    // ****************************************

    initial begin
        logic [31:0] base;
        logic [31:0] data;
        logic [1:0]  offs;
        mem_op_t     op;
        rst         = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        commit_tag  = TAG_NONE;
        fetch_req   = 1'b0;
        fetch_pc    = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);  // Outputs stay quiet here.

        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            waddr[i] = {22'd0, rng[9:2], 2'b00};  // Word aligned.
            rng = xorshift(rng);
            mem_access(SW, waddr[i], rng);
            mem_access(LW, waddr[i], '0);
        end

        for (int i = 0; i < 8; i++) begin
            rng  = xorshift(rng);
            op   = narrow_ops[i % 4];
            base = waddr[rng[1:0]];
            offs = (op == LB || op == LBU) ? rng[3:2] : {rng[3], 1'b0};
            mem_access(op, base + offs, '0);
        end

        for (int i = 0; i < 4; i++) begin
            rng  = xorshift(rng);
            op   = (i % 2 == 0) ? SB : SH;
            base = waddr[rng[1:0]];
            offs = (op == SB) ? rng[3:2] : {rng[3], 1'b0};
            data = xorshift(rng);
            mem_access(op, base + offs, data);
            mem_access(LW, base, '0);
        end

        // Six back-to-back fetches fill the queue up to the full level.
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            push_fetch(waddr[i % 4]);
        end
        @(posedge clk);
        fetch_req <= 1'b0;
        while (exp_fetch_q.size() != 0) @(posedge clk);

        repeat (3) @(posedge clk);
        cur_tag = (cur_tag == 3'd7) ? 3'd1 : cur_tag + 3'd1;
        issue_op(cur_tag, LW, waddr[2], '0);
        expect_result(cur_tag, LW, waddr[2], '0);
        @(posedge clk);
        push_fetch(waddr[3]);
        @(posedge clk);
        fetch_req  <= 1'b0;
        commit_tag <= cur_tag;  // Meets the queued fetch at the idle FSM.
        mem_first  <= 1'b1;
        wait_result(cur_tag);
        while (exp_fetch_q.size() != 0) @(posedge clk);

        repeat (4) @(posedge clk);
        if (exp_mem_q.size() != 0 || exp_fetch_q.size() != 0) begin
            report_fault("Some expected results never arrived.");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
lsb_pkg.sv
lsb_entry_buf.sv
fetch_queue.sv
mem_sequencer.sv
byte_ram.sv
lsb_top.sv
tb_lsb.sv
